/* source/admm_pkg.sv */
package admm_pkg;

    // Fixed-point format, Q8.8 inside the engine
    localparam int data_width = 16;
    localparam int frac_bits = 8;

    // Host bus
    localparam int bus_width = 32;
    localparam int bus_addr_width = 12;

    typedef logic signed [data_width-1:0] fix_t;

    localparam fix_t fix_max = {1'b0, {(data_width - 1){1'b1}}};
    localparam fix_t fix_min = {1'b1, {(data_width - 1){1'b0}}};

    localparam logic [data_width-1:0] default_max_iter = 100;

    // Per-entry solver state, dual and slack side by side
    typedef struct packed {
        fix_t y;
        fix_t z;
    } admm_var_t;

    typedef struct packed {
        logic [data_width-1:0] n;
        fix_t                  u_min;
        fix_t                  u_max;
        logic [data_width-1:0] pri_tol;
        logic [data_width-1:0] dual_tol;
        logic [data_width-1:0] max_iter;
    } solve_cfg_t;

    // One entry's contribution to the residuals
    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [data_width-1:0] pri_diff;
        logic [data_width-1:0] dual_diff;
    } elem_beat_t;

    typedef struct packed {
        logic [data_width-1:0] pri_res;
        logic [data_width-1:0] dual_res;
        logic                  converged;
    } residual_t;

    // Register map, word offsets
    localparam logic [bus_addr_width-1:0] reg_ctrl = 12'd0;
    localparam logic [bus_addr_width-1:0] reg_status = 12'd1;
    localparam logic [bus_addr_width-1:0] reg_iter = 12'd2;
    localparam logic [bus_addr_width-1:0] reg_length = 12'd3;
    localparam logic [bus_addr_width-1:0] reg_u_min = 12'd4;
    localparam logic [bus_addr_width-1:0] reg_u_max = 12'd5;
    localparam logic [bus_addr_width-1:0] reg_pri_tol = 12'd6;
    localparam logic [bus_addr_width-1:0] reg_dual_tol = 12'd7;
    localparam logic [bus_addr_width-1:0] reg_pri_res = 12'd8;
    localparam logic [bus_addr_width-1:0] reg_dual_res = 12'd9;
    localparam logic [bus_addr_width-1:0] reg_max_iter = 12'd10;

    // Vector windows, 256 words each
    localparam logic [bus_addr_width-1:0] win_u = 12'h100;
    localparam logic [bus_addr_width-1:0] win_z = 12'h200;
    localparam logic [bus_addr_width-1:0] win_y = 12'h300;

endpackage

/* source/vector_ram.sv */
`timescale 1ns/1ps

module vector_ram #(
    parameter int  depth = 64,
    parameter int  addr_width = 6,
    parameter type elem_t = logic
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  elem_t                 wr_data,
    input  logic [addr_width-1:0] eng_addr,
    output elem_t                 eng_data,
    input  logic [addr_width-1:0] host_addr,
    output elem_t                 host_data
);

    elem_t mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // Both read ports are registered
        eng_data <= mem[eng_addr];
        host_data <= mem[host_addr];
    end

endmodule

/* source/avalon_csr.sv */
`timescale 1ns/1ps

module avalon_csr #(
    parameter int elem_addr_width = 6
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [admm_pkg::bus_width-1:0]      writedata,
    input  logic                                read,
    input  logic                                write,
    input  logic                                chipselect,
    input  logic [admm_pkg::bus_addr_width-1:0] addr,
    output logic [admm_pkg::bus_width-1:0]      readdata,
    output admm_pkg::solve_cfg_t                cfg,
    output logic                                start,
    input  logic                                busy,
    input  logic                                done,
    input  logic [admm_pkg::bus_width-1:0]      iter,
    input  admm_pkg::residual_t                 result,
    input  logic                                result_done,
    output logic                                u_wr_en,
    output logic [elem_addr_width-1:0]          u_wr_addr,
    output admm_pkg::fix_t                      u_wr_data,
    output logic [elem_addr_width-1:0]          host_addr,
    input  admm_pkg::fix_t                      u_host_data,
    input  admm_pkg::admm_var_t                 state_host_data
);

    localparam int bw = admm_pkg::bus_width;
    localparam int dw = admm_pkg::data_width;

    typedef enum logic [1:0] {src_reg, src_u, src_z, src_y} rd_src_t;

    logic                                 wr_hit;
    logic                                 rd_hit;
    logic [admm_pkg::bus_addr_width-1:0]  win_base;
    logic [bw-1:0]                        reg_mux;
    logic [bw-1:0]                        reg_rdata;
    rd_src_t                              rd_src;
    admm_pkg::residual_t                  res_q;

    assign wr_hit = chipselect & write;
    assign rd_hit = chipselect & read;
    // Upper address bits pick the window
    assign win_base = {addr[admm_pkg::bus_addr_width-1:8], 8'h00};

    assign start = wr_hit && (addr == admm_pkg::reg_ctrl) && writedata[0] && !busy;

    assign u_wr_en = wr_hit && (win_base == admm_pkg::win_u);
    assign u_wr_addr = addr[elem_addr_width-1:0];
    assign u_wr_data = writedata[dw-1:0];
    assign host_addr = addr[elem_addr_width-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '{n: '0, u_min: '0, u_max: '0, pri_tol: '0, dual_tol: '0,
                     max_iter: admm_pkg::default_max_iter};
            res_q <= '0;
        end else begin
            if (wr_hit) begin
                case (addr)
                    admm_pkg::reg_length:   cfg.n <= writedata[dw-1:0];
                    admm_pkg::reg_u_min:    cfg.u_min <= writedata[dw-1:0];
                    admm_pkg::reg_u_max:    cfg.u_max <= writedata[dw-1:0];
                    admm_pkg::reg_pri_tol:  cfg.pri_tol <= writedata[dw-1:0];
                    admm_pkg::reg_dual_tol: cfg.dual_tol <= writedata[dw-1:0];
                    admm_pkg::reg_max_iter: cfg.max_iter <= writedata[dw-1:0];
                    default: ;
                endcase
            end
            // Keep the latest iteration's residuals
            if (result_done) begin
                res_q <= result;
            end
        end
    end

    always_comb begin
        case (addr)
            admm_pkg::reg_status:   reg_mux = bw'({res_q.converged, done, busy});
            admm_pkg::reg_iter:     reg_mux = iter;
            admm_pkg::reg_length:   reg_mux = bw'(cfg.n);
            admm_pkg::reg_u_min:    reg_mux = bw'(cfg.u_min);
            admm_pkg::reg_u_max:    reg_mux = bw'(cfg.u_max);
            admm_pkg::reg_pri_tol:  reg_mux = bw'(cfg.pri_tol);
            admm_pkg::reg_dual_tol: reg_mux = bw'(cfg.dual_tol);
            admm_pkg::reg_pri_res:  reg_mux = bw'(res_q.pri_res);
            admm_pkg::reg_dual_res: reg_mux = bw'(res_q.dual_res);
            admm_pkg::reg_max_iter: reg_mux = bw'(cfg.max_iter);
            default:                reg_mux = '0;
        endcase
    end

    // RAM host ports already carry one cycle of latency
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            reg_rdata <= reg_mux;
            if (win_base == admm_pkg::win_u) begin
                rd_src <= src_u;
            end else if (win_base == admm_pkg::win_z) begin
                rd_src <= src_z;
            end else if (win_base == admm_pkg::win_y) begin
                rd_src <= src_y;
            end else begin
                rd_src <= src_reg;
            end
        end
    end

    // Vector entries are sign extended onto the bus
    always_comb begin
        case (rd_src)
            src_u:   readdata = bw'(u_host_data);
            src_z:   readdata = bw'(state_host_data.z);
            src_y:   readdata = bw'(state_host_data.y);
            default: readdata = reg_rdata;
        endcase
    end

endmodule

/* source/solver_ctrl.sv */
`timescale 1ns/1ps

module solver_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  admm_pkg::solve_cfg_t           cfg,
    input  logic                           start,
    input  admm_pkg::residual_t            result,
    input  logic                           result_done,
    output logic                           iter_start,
    output logic                           first_iter,
    output logic                           busy,
    output logic                           done,
    output logic [admm_pkg::bus_width-1:0] iter
);

    localparam int bw = admm_pkg::bus_width;

    typedef enum logic [1:0] {st_idle, st_run, st_wait} state_t;

    state_t        state;
    logic [bw-1:0] iter_next;
    logic          at_limit;

    // One cycle in st_run launches a sweep of the stage
    assign iter_start = (state == st_run);

    assign iter_next = iter + 1'b1;
    assign at_limit = (iter_next >= bw'(cfg.max_iter));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            first_iter <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            iter <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        first_iter <= 1'b1;
                        busy <= 1'b1;
                        done <= 1'b0;
                        iter <= '0;
                    end
                end
                st_run: begin
                    state <= st_wait;
                end
                st_wait: begin
                    if (result_done) begin
                        iter <= iter_next;
                        if (result.converged || at_limit) begin
                            state <= st_idle;
                            busy <= 1'b0;
                            done <= 1'b1;
                        end else begin
                            state <= st_run;
                            first_iter <= 1'b0;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* source/slack_dual_stage.sv */
`timescale 1ns/1ps

module slack_dual_stage #(
    parameter int elem_addr_width = 6
) (
    input  logic                       clk,
    input  logic                       rst,
    input  admm_pkg::solve_cfg_t       cfg,
    input  logic                       iter_start,
    input  logic                       first_iter,
    output logic [elem_addr_width-1:0] u_addr,
    output logic [elem_addr_width-1:0] state_rd_addr,
    input  admm_pkg::fix_t             u_data,
    input  admm_pkg::admm_var_t        state_data,
    output logic                       state_wr_en,
    output logic [elem_addr_width-1:0] state_wr_addr,
    output admm_pkg::admm_var_t        state_wr_data,
    output admm_pkg::elem_beat_t       beat
);

    localparam int dw = admm_pkg::data_width;

    // Issue stage
    logic                       active;
    logic                       first_q;
    logic [dw-1:0]              idx;
    logic                       idx_last;
    // Read stage
    logic                       rd_valid;
    logic                       rd_last;
    logic [elem_addr_width-1:0] rd_idx;
    // Write-back stage
    logic                       wb_valid;
    logic                       wb_last;
    logic [elem_addr_width-1:0] wb_idx;
    admm_pkg::admm_var_t        wb_var;
    logic [dw-1:0]              wb_pri;
    logic [dw-1:0]              wb_dual;

    admm_pkg::fix_t      y_old;
    admm_pkg::fix_t      z_old;
    admm_pkg::fix_t      z_new;
    admm_pkg::fix_t      y_new;
    logic signed [dw:0]   sum;
    logic signed [dw:0]   pri_d;
    logic signed [dw:0]   dual_d;
    logic signed [dw:0]   pri_mag;
    logic signed [dw:0]   dual_mag;
    logic signed [dw+1:0] y_sum;

    assign idx_last = (idx == cfg.n - 1'b1);
    assign u_addr = idx[elem_addr_width-1:0];
    assign state_rd_addr = idx[elem_addr_width-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            first_q <= 1'b0;
            idx <= '0;
            rd_valid <= 1'b0;
            rd_last <= 1'b0;
            wb_valid <= 1'b0;
            wb_last <= 1'b0;
        end else begin
            rd_valid <= active;
            rd_last <= active & idx_last;
            wb_valid <= rd_valid;
            wb_last <= rd_last;
            if (iter_start) begin
                active <= 1'b1;
                first_q <= first_iter;
                idx <= '0;
            end else if (active) begin
                idx <= idx + 1'b1;
                if (idx_last) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        // Previous state counts as zero on the first sweep
        y_old = first_q ? '0 : state_data.y;
        z_old = first_q ? '0 : state_data.z;
        sum = u_data + y_old;
        if (sum < cfg.u_min) begin
            z_new = cfg.u_min;
        end else if (sum > cfg.u_max) begin
            z_new = cfg.u_max;
        end else begin
            z_new = sum[dw-1:0];
        end
        y_sum = y_old + u_data - z_new;
        if (y_sum > admm_pkg::fix_max) begin
            y_new = admm_pkg::fix_max;
        end else if (y_sum < admm_pkg::fix_min) begin
            y_new = admm_pkg::fix_min;
        end else begin
            y_new = y_sum[dw-1:0];
        end
        pri_d = u_data - z_new;
        dual_d = z_new - z_old;
        pri_mag = pri_d[dw] ? -pri_d : pri_d;
        dual_mag = dual_d[dw] ? -dual_d : dual_d;
    end

    always_ff @(posedge clk) begin
        rd_idx <= u_addr;
        wb_idx <= rd_idx;
        wb_var <= '{y: y_new, z: z_new};
        wb_pri <= pri_mag[dw-1:0];
        wb_dual <= dual_mag[dw-1:0];
    end

    assign state_wr_en = wb_valid;
    assign state_wr_addr = wb_idx;
    assign state_wr_data = wb_var;
    assign beat = '{valid: wb_valid, last: wb_last, pri_diff: wb_pri, dual_diff: wb_dual};

endmodule

/* source/residual_tracker.sv */
`timescale 1ns/1ps

module residual_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  admm_pkg::solve_cfg_t cfg,
    input  admm_pkg::elem_beat_t beat,
    output admm_pkg::residual_t  result,
    output logic                 result_done
);

    localparam int dw = admm_pkg::data_width;

    logic [dw-1:0] pri_max;
    logic [dw-1:0] dual_max;
    logic [dw-1:0] pri_next;
    logic [dw-1:0] dual_next;

    assign pri_next = (beat.pri_diff > pri_max) ? beat.pri_diff : pri_max;
    assign dual_next = (beat.dual_diff > dual_max) ? beat.dual_diff : dual_max;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pri_max <= '0;
            dual_max <= '0;
            result <= '0;
            result_done <= 1'b0;
        end else begin
            result_done <= beat.valid & beat.last;
            if (beat.valid) begin
                if (beat.last) begin
                    // Sweep finished, publish and start over
                    pri_max <= '0;
                    dual_max <= '0;
                    result.pri_res <= pri_next;
                    result.dual_res <= dual_next;
                    result.converged <= (pri_next <= cfg.pri_tol) &&
                                        (dual_next <= cfg.dual_tol);
                end else begin
                    pri_max <= pri_next;
                    dual_max <= dual_next;
                end
            end
        end
    end

endmodule

/* source/admm_solver.sv */
`timescale 1ns/1ps

module admm_solver #(
    parameter int max_elems = 64,
    parameter int elem_addr_width = 6
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [admm_pkg::bus_width-1:0]        writedata,
    input  logic                                  read,
    input  logic                                  write,
    input  logic                                  chipselect,
    input  logic [admm_pkg::bus_addr_width-1:0]   addr,
    output logic [admm_pkg::bus_width-1:0]        readdata
);

    admm_pkg::solve_cfg_t        cfg;
    admm_pkg::residual_t         result;
    admm_pkg::elem_beat_t        beat;
    logic                        start;
    logic                        busy;
    logic                        done;
    logic                        result_done;
    logic                        iter_start;
    logic                        first_iter;
    logic [admm_pkg::bus_width-1:0] iter;

    // Host side of the memories
    logic                        u_wr_en;
    logic [elem_addr_width-1:0]  u_wr_addr;
    admm_pkg::fix_t              u_wr_data;
    logic [elem_addr_width-1:0]  host_addr;
    admm_pkg::fix_t              u_host_data;
    admm_pkg::admm_var_t         state_host_data;

    // Engine side
    logic [elem_addr_width-1:0]  u_eng_addr;
    admm_pkg::fix_t              u_eng_data;
    logic [elem_addr_width-1:0]  state_rd_addr;
    admm_pkg::admm_var_t         state_eng_data;
    logic                        state_wr_en;
    logic [elem_addr_width-1:0]  state_wr_addr;
    admm_pkg::admm_var_t         state_wr_data;

    avalon_csr #(.elem_addr_width(elem_addr_width)) csr (
        .clk(clk), .rst(rst),
        .writedata(writedata), .read(read), .write(write),
        .chipselect(chipselect), .addr(addr), .readdata(readdata),
        .cfg(cfg), .start(start), .busy(busy), .done(done), .iter(iter),
        .result(result), .result_done(result_done),
        .u_wr_en(u_wr_en), .u_wr_addr(u_wr_addr), .u_wr_data(u_wr_data),
        .host_addr(host_addr), .u_host_data(u_host_data),
        .state_host_data(state_host_data)
    );

    // Input trajectory, loaded by the host
    vector_ram #(
        .depth(max_elems), .addr_width(elem_addr_width), .elem_t(admm_pkg::fix_t)
    ) u_ram (
        .clk(clk), .wr_en(u_wr_en), .wr_addr(u_wr_addr), .wr_data(u_wr_data),
        .eng_addr(u_eng_addr), .eng_data(u_eng_data),
        .host_addr(host_addr), .host_data(u_host_data)
    );

    // Dual and slack pairs, owned by the engine
    vector_ram #(
        .depth(max_elems), .addr_width(elem_addr_width), .elem_t(admm_pkg::admm_var_t)
    ) state_ram (
        .clk(clk), .wr_en(state_wr_en), .wr_addr(state_wr_addr), .wr_data(state_wr_data),
        .eng_addr(state_rd_addr), .eng_data(state_eng_data),
        .host_addr(host_addr), .host_data(state_host_data)
    );

    solver_ctrl ctrl (
        .clk(clk), .rst(rst), .cfg(cfg), .start(start),
        .result(result), .result_done(result_done),
        .iter_start(iter_start), .first_iter(first_iter),
        .busy(busy), .done(done), .iter(iter)
    );

    slack_dual_stage #(.elem_addr_width(elem_addr_width)) stage (
        .clk(clk), .rst(rst), .cfg(cfg),
        .iter_start(iter_start), .first_iter(first_iter),
        .u_addr(u_eng_addr), .state_rd_addr(state_rd_addr),
        .u_data(u_eng_data), .state_data(state_eng_data),
        .state_wr_en(state_wr_en), .state_wr_addr(state_wr_addr),
        .state_wr_data(state_wr_data), .beat(beat)
    );

    residual_tracker tracker (
        .clk(clk), .rst(rst), .cfg(cfg), .beat(beat),
        .result(result), .result_done(result_done)
    );

endmodule

/* dv/admm_solver_tb.sv */
`timescale 1ns/1ps

module admm_solver_tb;

    localparam int max_elems = 64;
    localparam int elem_addr_width = 6;
    localparam int num_cases = 6;
    localparam int clk_period = 8;

    // Configuration, range of u and expected outcome of one solve
    typedef struct packed {
        int n;
        int u_min;
        int u_max;
        int pri_tol;
        int dual_tol;
        int max_iter;
        int u_lo;
        int u_hi;
        int exp_iter;
        int exp_conv;
    } case_t;

    logic                                clk;
    logic                                rst;
    logic [admm_pkg::bus_width-1:0]      writedata;
    logic                                read;
    logic                                write;
    logic                                chipselect;
    logic [admm_pkg::bus_addr_width-1:0] addr;
    logic [admm_pkg::bus_width-1:0]      readdata;

    int          errors;
    int          checks;
    logic [31:0] rng;

    // Reference copies of u, z and y across solves
    int u_m [max_elems];
    int z_m [max_elems];
    int y_m [max_elems];
    bit known [max_elems];

    admm_solver #(.max_elems(max_elems), .elem_addr_width(elem_addr_width)) uut (
        .clk(clk), .rst(rst), .writedata(writedata), .read(read), .write(write),
        .chipselect(chipselect), .addr(addr), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Each row holds n, u_min, u_max, pri_tol, dual_tol, max_iter, u_lo, u_hi,
    // the expected iteration count (0 for any) and converged (-1 for any)
    function automatic case_t table_entry(input int k);
        case_t c;
        case (k)
            // All of u inside the bounds
            0: c = '{8, -1024, 1024, 0, 0, 20, -512, 512, 2, 1};
            // Far outside the bounds so that y saturates
            1: c = '{16, -256, 256, 0, 0, 6, -32000, 32000, 6, 0};
            2: c = '{1, -300, 500, 40, 40, 15, -800, 800, 0, -1};
            3: c = '{64, -2000, 1500, 600, 100, 12, -3000, 3000, 0, -1};
            4: c = '{37, -100, 100, 300, 0, 10, -400, 400, 0, -1};
            // Shorter rerun leaves the upper entries as they were
            5: c = '{5, -500, 500, 0, 0, 8, -1000, 1000, 0, -1};
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int draw(input int lo, input int hi);
        rng = xorshift(rng);
        return lo + int'(rng % 32'(hi - lo + 1));
    endfunction

    function automatic logic [31:0] sext16(input int v);
        logic [15:0] w;
        w = 16'(v);
        return {{16{w[15]}}, w};
    endfunction

    // Projection and dual update per entry until the exit rule holds
    task automatic run_model(input case_t c, output int iters, output int pri,
                             output int dual, output bit conv);
        int i;
        int yo;
        int zo;
        int s;
        int z;
        int yn;
        int d;
        bit stop;
        iters = 0;
        stop = 1'b0;
        while (!stop) begin
            pri = 0;
            dual = 0;
            for (i = 0; i < c.n; i++) begin
                yo = (iters == 0) ? 0 : y_m[i];
                zo = (iters == 0) ? 0 : z_m[i];
                s = u_m[i] + yo;
                z = (s < c.u_min) ? c.u_min : ((s > c.u_max) ? c.u_max : s);
                yn = yo + u_m[i] - z;
                if (yn > 32767) begin
                    yn = 32767;
                end
                if (yn < -32768) begin
                    yn = -32768;
                end
                d = (u_m[i] > z) ? u_m[i] - z : z - u_m[i];
                if (d > pri) begin
                    pri = d;
                end
                d = (z > zo) ? z - zo : zo - z;
                if (d > dual) begin
                    dual = d;
                end
                z_m[i] = z;
                y_m[i] = yn;
                known[i] = 1'b1;
            end
            iters++;
            conv = (pri <= c.pri_tol) && (dual <= c.dual_tol);
            stop = conv || (iters >= c.max_iter);
        end
    endtask

    task automatic bus_write(input logic [11:0] a, input logic [31:0] d);
        @(posedge clk);
        chipselect <= 1'b1;
        write <= 1'b1;
        addr <= a;
        writedata <= d;
        @(posedge clk);
        chipselect <= 1'b0;
        write <= 1'b0;
    endtask

    // Data is sampled mid-cycle after the read edge
    task automatic bus_read(input logic [11:0] a, output logic [31:0] d);
        @(posedge clk);
        chipselect <= 1'b1;
        read <= 1'b1;
        addr <= a;
        @(posedge clk);
        chipselect <= 1'b0;
        read <= 1'b0;
        @(negedge clk);
        d = readdata;
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_and_compare(input logic [11:0] a, input logic [31:0] exp,
                                    input string what);
        logic [31:0] d;
        bus_read(a, d);
        compare_word(what, d, exp);
    endtask

    task automatic run_case(input int k, input case_t c);
        int          iters;
        int          pri;
        int          dual;
        bit          conv;
        int          i;
        logic [31:0] status;
        logic [31:0] iter_rd;
        for (i = 0; i < c.n; i++) begin
            u_m[i] = draw(c.u_lo, c.u_hi);
            bus_write(admm_pkg::win_u + 12'(i), 32'(u_m[i]));
        end
        bus_write(admm_pkg::reg_length, 32'(c.n));
        bus_write(admm_pkg::reg_u_min, 32'(c.u_min));
        bus_write(admm_pkg::reg_u_max, 32'(c.u_max));
        bus_write(admm_pkg::reg_pri_tol, 32'(c.pri_tol));
        bus_write(admm_pkg::reg_dual_tol, 32'(c.dual_tol));
        bus_write(admm_pkg::reg_max_iter, 32'(c.max_iter));
        read_and_compare(admm_pkg::reg_length, 32'(c.n), "length");
        read_and_compare(admm_pkg::reg_u_min, sext16(c.u_min), "u_min");
        read_and_compare(admm_pkg::reg_u_max, sext16(c.u_max), "u_max");
        read_and_compare(admm_pkg::reg_pri_tol, 32'(c.pri_tol), "pri_tol");
        read_and_compare(admm_pkg::reg_dual_tol, 32'(c.dual_tol), "dual_tol");
        read_and_compare(admm_pkg::reg_max_iter, 32'(c.max_iter), "max_iter");

        run_model(c, iters, pri, dual, conv);
        bus_write(admm_pkg::reg_ctrl, 32'd1);
        // A sweep outlasts the first poll, so busy is up and done is low
        bus_read(admm_pkg::reg_status, status);
        compare_word("status after start", 32'(status[1:0]), 32'd1);
        while (status[1] == 1'b0) begin
            bus_read(admm_pkg::reg_status, status);
        end
        $display("Case %0d: n=%0d, %0d iterations expected", k, c.n, iters);

        compare_word("status", status, 32'({conv, 2'b10}));
        bus_read(admm_pkg::reg_iter, iter_rd);
        compare_word("iteration count", iter_rd, 32'(iters));
        if (c.exp_iter > 0) begin
            compare_word("iteration count from table", iter_rd, 32'(c.exp_iter));
        end
        if (c.exp_conv >= 0) begin
            compare_word("converged from table", 32'(status[2]), 32'(c.exp_conv));
        end
        read_and_compare(admm_pkg::reg_pri_res, 32'(pri), "pri_res");
        read_and_compare(admm_pkg::reg_dual_res, 32'(dual), "dual_res");

        // Every entry written so far, also those beyond n
        for (i = 0; i < max_elems; i++) begin
            if (known[i]) begin
                read_and_compare(admm_pkg::win_u + 12'(i), sext16(u_m[i]),
                                 $sformatf("u[%0d]", i));
                read_and_compare(admm_pkg::win_z + 12'(i), sext16(z_m[i]),
                                 $sformatf("z[%0d]", i));
                read_and_compare(admm_pkg::win_y + 12'(i), sext16(y_m[i]),
                                 $sformatf("y[%0d]", i));
            end
        end
    endtask

    initial begin
        int k;
        errors = 0;
        checks = 0;
        rng = 32'hf474;
        rst = 1'b1;
        writedata = '0;
        read = 1'b0;
        write = 1'b0;
        chipselect = 1'b0;
        addr = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        read_and_compare(admm_pkg::reg_status, 32'd0, "status after reset");
        read_and_compare(admm_pkg::reg_iter, 32'd0, "iter after reset");
        read_and_compare(admm_pkg::reg_pri_res, 32'd0, "pri_res after reset");
        read_and_compare(admm_pkg::reg_dual_res, 32'd0, "dual_res after reset");
        read_and_compare(admm_pkg::reg_max_iter, 32'd100, "max_iter after reset");

        for (k = 0; k < num_cases; k++) begin
            run_case(k, table_entry(k));
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Cycle budget for sweeps, loading and readback with a factor of two margin
    initial begin
        int    k;
        int    budget;
        case_t c;
        budget = 500;
        for (k = 0; k < num_cases; k++) begin
            c = table_entry(k);
            budget += c.max_iter * (c.n + 10) + 12 * c.n + 600;
        end
        #(budget * 2 * clk_period);
        $display("Timeout: the solver did not report done within %0d cycles", 2 * budget);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* admm_solver.f */
source/admm_pkg.sv
source/vector_ram.sv
source/avalon_csr.sv
source/solver_ctrl.sv
source/slack_dual_stage.sv
source/residual_tracker.sv
source/admm_solver.sv
dv/admm_solver_tb.sv

/* Bender.yml */
package:
  name: admm_solver

sources:
  - source/admm_pkg.sv
  - source/vector_ram.sv
  - source/avalon_csr.sv
  - source/solver_ctrl.sv
  - source/slack_dual_stage.sv
  - source/residual_tracker.sv
  - source/admm_solver.sv
  - target: test
    files:
      - dv/admm_solver_tb.sv
